// File: include/serial_core_config.svh
`ifndef SERIAL_CORE_CONFIG_SVH
`define SERIAL_CORE_CONFIG_SVH

`define NUM_REGS 32

// opcode field, instruction bits 6:2.
`define OPC_OP_IMM 5'b00100
`define OPC_OP     5'b01100
`define OPC_LUI    5'b01101

// alu result source.
`define ALU_RD_ADD  2'd0
`define ALU_RD_BOOL 2'd1
`define ALU_RD_LT   2'd2

`endif

// File: design/serial_core_pkg.sv
`default_nettype none

package serial_core_pkg;

   // one data word, sent lsb first.
   typedef logic [31:0] word_t;

   typedef logic [4:0] reg_addr_t;

   // position of the current serial bit.
   typedef logic [4:0] bit_cnt_t;

   typedef logic [4:0] opcode_t;

   typedef logic [2:0] funct3_t;

   typedef logic [1:0] alu_rd_sel_t;

   // INIT is the first pass of a two-pass instruction.
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      INIT = 2'd1,
      RUN  = 2'd2
   } decode_state_t;

endpackage

`default_nettype wire

// File: design/serial_decode.sv
`default_nettype none
`include "serial_core_config.svh"

module serial_decode import serial_core_pkg::*; (
   input  wire          clk,
   input  wire          i_rst,
   input  wire          i_wb_en,
   input  wire word_t   i_wb_rdt,
   output logic         o_busy,
   output bit_cnt_t     o_cnt,
   output logic         o_cnt_en,
   output logic         o_first,
   output logic         o_last,
   output logic         o_run,
   output logic         o_imm,
   output logic         o_op_b_imm,
   output logic         o_alu_sub,
   output logic [1:0]   o_bool_op,
   output logic         o_cmp_uns,
   output alu_rd_sel_t  o_rd_sel,
   output reg_addr_t    o_rs1_addr,
   output reg_addr_t    o_rs2_addr,
   output reg_addr_t    o_rd_addr,
   output logic         o_rd_we
);

   decode_state_t state;
   bit_cnt_t      cnt;
   logic          retire_wait;

   opcode_t   opcode;
   funct3_t   funct3;
   logic      op30;
   reg_addr_t rd_addr;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     imm;

   opcode_t   new_opcode;
   funct3_t   new_funct3;
   word_t     new_imm;
   logic      new_two_pass;
   logic      accept;

   logic      is_op_imm;
   logic      is_op;
   logic      is_lui;
   logic      alu_op_ok;
   logic      supported;

   assign new_opcode = i_wb_rdt[6:2];
   assign new_funct3 = i_wb_rdt[14:12];

   // slt family needs a compare pass first.
   assign new_two_pass = ((new_opcode == `OPC_OP_IMM) | (new_opcode == `OPC_OP)) &
                         (new_funct3[2:1] == 2'b01);

   assign new_imm = (new_opcode == `OPC_LUI) ? {i_wb_rdt[31:12], 12'd0} :
                                               {{20{i_wb_rdt[31]}}, i_wb_rdt[31:20]};

   assign accept = i_wb_en & ~o_busy; // dropped while busy.

   always_ff @(posedge clk) begin
      if (accept) begin
         opcode   <= new_opcode;
         funct3   <= new_funct3;
         op30     <= i_wb_rdt[30];
         rd_addr  <= i_wb_rdt[11:7];
         rs1_addr <= i_wb_rdt[19:15];
         rs2_addr <= i_wb_rdt[24:20];
         imm      <= new_imm;
      end else if (o_cnt_en) begin
         imm <= {imm[0], imm[31:1]}; // rotate, so a second pass sees it again.
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state       <= IDLE;
         cnt         <= '0;
         retire_wait <= 1'b0;
      end else begin
         cnt         <= cnt + {4'd0, o_cnt_en};
         retire_wait <= o_run & o_last;
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= new_two_pass ? INIT : RUN;
               end
            end
            INIT: begin
               if (o_last) begin
                  state <= RUN;
               end
            end
            RUN: begin
               if (o_last) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // busy covers the cycle while the regfile reports.
   assign o_busy   = (state != IDLE) | retire_wait;
   assign o_cnt    = cnt;
   assign o_cnt_en = (state != IDLE);
   assign o_run    = (state == RUN);
   assign o_first  = (cnt == 5'd0);
   assign o_last   = (cnt == 5'd31);
   assign o_imm    = imm[0];

   assign is_op_imm = (opcode == `OPC_OP_IMM);
   assign is_op     = (opcode == `OPC_OP);
   assign is_lui    = (opcode == `OPC_LUI);

   // shifts are not implemented.
   assign alu_op_ok = (is_op | is_op_imm) & (funct3[1:0] != 2'b01);
   assign supported = is_lui | alu_op_ok;

   assign o_op_b_imm = ~is_op;
   assign o_alu_sub  = (state == INIT) | (is_op & (funct3 == 3'b000) & op30);
   assign o_bool_op  = funct3[1:0];
   assign o_cmp_uns  = funct3[0];

   assign o_rs1_addr = is_lui ? 5'd0 : rs1_addr; // lui is x0 + imm.
   assign o_rs2_addr = rs2_addr;
   assign o_rd_addr  = rd_addr;
   assign o_rd_we    = supported & (rd_addr != 5'd0);

   always_comb begin
      if (is_lui) begin
         o_rd_sel = `ALU_RD_ADD;
      end else begin
         case (funct3)
            3'b010,
            3'b011: o_rd_sel = `ALU_RD_LT;
            3'b100,
            3'b110,
            3'b111: o_rd_sel = `ALU_RD_BOOL;
            default: o_rd_sel = `ALU_RD_ADD;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/serial_regfile.sv
`default_nettype none
`include "serial_core_config.svh"

module serial_regfile import serial_core_pkg::*; (
   input  wire            clk,
   input  wire            i_rst,
   input  wire bit_cnt_t  i_cnt,
   input  wire            i_run,
   input  wire            i_last,
   input  wire reg_addr_t i_rs1_addr,
   input  wire reg_addr_t i_rs2_addr,
   input  wire reg_addr_t i_rd_addr,
   input  wire            i_rd_we,
   input  wire            i_rd_bit,
   output logic           o_rs1,
   output logic           o_rs2,
   output logic           o_retire,
   output logic           o_rd_we,
   output reg_addr_t      o_rd_addr,
   output word_t          o_rd_data
);

   word_t regs [`NUM_REGS];
   word_t wbuf;
   logic  wbuf_vld;
   logic  commit;

   // x0 is never written, so it is muxed to zero.
   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

   assign commit = i_run & i_last;

   always_ff @(posedge clk) begin
      if (i_run) begin
         wbuf <= {i_rd_bit, wbuf[31:1]}; // lsb arrives first.
      end
      if (commit) begin
         o_rd_we   <= i_rd_we;
         o_rd_addr <= i_rd_addr;
      end
      if (commit & i_rd_we & (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr] <= {i_rd_bit, wbuf[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         wbuf_vld <= 1'b0;
         o_retire <= 1'b0;
      end else begin
         wbuf_vld <= commit;
         o_retire <= wbuf_vld;
      end
   end

   // wbuf holds until the next run pass begins.
   assign o_rd_data = wbuf;

endmodule

`default_nettype wire

// File: design/serial_alu.sv
`default_nettype none
`include "serial_core_config.svh"

module serial_alu import serial_core_pkg::*; (
   input  wire              clk,
   input  wire              i_rst,
   input  wire              i_cnt_en,
   input  wire              i_first,
   input  wire              i_last,
   input  wire              i_run,
   input  wire              i_rs1,
   input  wire              i_rs2,
   input  wire              i_imm,
   input  wire              i_op_b_imm,
   input  wire              i_sub,
   input  wire [1:0]        i_bool_op,
   input  wire              i_cmp_uns,
   input  wire alu_rd_sel_t i_rd_sel,
   output logic             o_rd
);

   logic op_b;
   logic b_add;
   logic cin;
   logic sum;
   logic cout;
   logic carry;
   logic bool_bit;
   logic lt_bit;
   logic cmp_r;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   assign b_add = op_b ^ i_sub; // invert b, +1 enters as carry-in.
   assign cin   = i_first ? i_sub : carry;
   assign sum   = i_rs1 ^ b_add ^ cin;
   assign cout  = (i_rs1 & b_add) | (i_rs1 & cin) | (b_add & cin);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= cout;
      end
   end

   // at the sign bit, differing signs decide on their own.
   assign lt_bit = i_cmp_uns ? ~cout :
                   (i_rs1 ^ op_b) ? i_rs1 : sum;

   always_ff @(posedge clk) begin
      if (i_cnt_en & i_last & ~i_run) begin
         cmp_r <= lt_bit;
      end
   end

   always_comb begin
      case (i_bool_op)
         2'b00: bool_bit = i_rs1 ^ op_b;
         2'b10: bool_bit = i_rs1 | op_b;
         2'b11: bool_bit = i_rs1 & op_b;
         default: bool_bit = 1'b0;
      endcase
   end

   always_comb begin
      case (i_rd_sel)
         `ALU_RD_BOOL: o_rd = bool_bit;
         `ALU_RD_LT: o_rd = i_first & cmp_r; // 0 or 1.
         default: o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// File: design/serial_core.sv
`default_nettype none

module serial_core import serial_core_pkg::*; (
   input  wire        clk,
   input  wire        i_rst,
   input  wire        i_wb_en,
   input  wire word_t i_wb_rdt,
   output logic       o_busy,
   output logic       o_retire,
   output logic       o_rd_we,
   output reg_addr_t  o_rd_addr,
   output word_t      o_rd_data
);

   bit_cnt_t    cnt;
   logic        cnt_en;
   logic        first;
   logic        last;
   logic        run;
   logic        imm;
   logic        op_b_imm;
   logic        alu_sub;
   logic [1:0]  bool_op;
   logic        cmp_uns;
   alu_rd_sel_t rd_sel;
   reg_addr_t   rs1_addr;
   reg_addr_t   rs2_addr;
   reg_addr_t   rd_addr;
   logic        rd_we;
   logic        rs1;
   logic        rs2;
   logic        rd_bit;

   serial_decode decode (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_wb_en    (i_wb_en),
      .i_wb_rdt   (i_wb_rdt),
      .o_busy     (o_busy),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_first    (first),
      .o_last     (last),
      .o_run      (run),
      .o_imm      (imm),
      .o_op_b_imm (op_b_imm),
      .o_alu_sub  (alu_sub),
      .o_bool_op  (bool_op),
      .o_cmp_uns  (cmp_uns),
      .o_rd_sel   (rd_sel),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_rd_we    (rd_we)
   );

   serial_regfile regfile (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_cnt      (cnt),
      .i_run      (run),
      .i_last     (last),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_we    (rd_we),
      .i_rd_bit   (rd_bit),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .o_retire   (o_retire),
      .o_rd_we    (o_rd_we),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data)
   );

   serial_alu alu (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_cnt_en   (cnt_en),
      .i_first    (first),
      .i_last     (last),
      .i_run      (run),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_op_b_imm (op_b_imm),
      .i_sub      (alu_sub),
      .i_bool_op  (bool_op),
      .i_cmp_uns  (cmp_uns),
      .i_rd_sel   (rd_sel),
      .o_rd       (rd_bit)
   );

endmodule

`default_nettype wire

// File: tb/serial_core_asserts.sv
`default_nettype none

module serial_core_asserts import serial_core_pkg::*; (
   input wire            clk,
   input wire            i_rst,
   input wire            o_busy,
   input wire            o_retire,
   input wire            o_rd_we,
   input wire reg_addr_t o_rd_addr
);
   timeunit 1ns;
   timeprecision 1ns;

   retire_one_cycle: assert property (@(posedge clk) disable iff (i_rst)
      o_retire |=> !o_retire)
      else $error("o_retire stayed high for two cycles");

   // slice is ready for a new strobe while it reports.
   idle_on_retire: assert property (@(posedge clk) disable iff (i_rst)
      o_retire |-> !o_busy)
      else $error("o_busy high in the o_retire cycle");

   no_x0_write: assert property (@(posedge clk) disable iff (i_rst)
      (o_retire && o_rd_we) |-> (o_rd_addr != 5'd0))
      else $error("register write reported for x0");

endmodule

`default_nettype wire

// File: tb/serial_core_tb.sv
`default_nettype none
`include "serial_core_config.svh"

module serial_core_tb import serial_core_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ns;

   localparam int MAX_INSTR    = 200;
   localparam int RETIRE_LIMIT = 100;

   logic      clk;
   logic      i_rst;
   logic      i_wb_en;
   word_t     i_wb_rdt;
   logic      o_busy;
   logic      o_retire;
   logic      o_rd_we;
   reg_addr_t o_rd_addr;
   word_t     o_rd_data;

   word_t       model [`NUM_REGS]; // expected register contents.
   logic [31:0] lcg_state = 32'hc966_a445;
   int          errors = 0;
   int          checks = 0;

   serial_core serial_core_inst (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_wb_en   (i_wb_en),
      .i_wb_rdt  (i_wb_rdt),
      .o_busy    (o_busy),
      .o_retire  (o_retire),
      .o_rd_we   (o_rd_we),
      .o_rd_addr (o_rd_addr),
      .o_rd_data (o_rd_data)
   );

   bind serial_core serial_core_asserts serial_core_asserts_inst (
      .clk(clk), .i_rst(i_rst), .o_busy(o_busy), .o_retire(o_retire),
      .o_rd_we(o_rd_we), .o_rd_addr(o_rd_addr));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // every instruction at the two-pass latency, plus reset and idle gaps.
   initial begin
      #((MAX_INSTR * 66 + 1000) * 100);
      $display("watchdog expired before the tests finished");
      $display("STATUS: FAIL");
      $finish;
   end

   function automatic word_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // rv32i integer rules, slt family gives 0 or 1.
   function automatic word_t expected_result(funct3_t f3, logic alt, word_t a, word_t b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b010:  return {31'd0, $signed(a) < $signed(b)};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: return 32'd0;
      endcase
   endfunction

   task automatic compare_value(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // stray is strobed once mid-instruction when nonzero.
   task automatic run_instr(input word_t instr, input logic we, input reg_addr_t rd,
                            input word_t exp, input int latency, input word_t stray);
      int cycles;
      i_wb_en  = 1'b1;
      i_wb_rdt = instr;
      @(negedge clk);
      i_wb_en = 1'b0;
      compare_value("o_busy", {31'd0, o_busy}, 32'd1);
      cycles = 1;
      while (o_retire !== 1'b1 && cycles < RETIRE_LIMIT) begin
         i_wb_en  = (stray != 32'd0) && (cycles == 6);
         i_wb_rdt = i_wb_en ? stray : i_wb_rdt;
         @(negedge clk);
         cycles++;
      end
      assert (o_retire === 1'b1) else begin
         $display("instruction %h never retired", instr);
         errors++;
      end
      compare_value("retire cycles", cycles, latency);
      compare_value("o_rd_we", {31'd0, o_rd_we}, {31'd0, we});
      compare_value("o_rd_addr", {27'd0, o_rd_addr}, {27'd0, rd});
      if (we) begin
         compare_value("o_rd_data", o_rd_data, exp);
         model[rd] = exp;
      end
   endtask

   task automatic op_imm(input funct3_t f3, input reg_addr_t rd, input reg_addr_t rs1,
                         input logic [11:0] imm);
      word_t exp;
      exp = expected_result(f3, 1'b0, model[rs1], {{20{imm[11]}}, imm});
      run_instr({imm, rs1, f3, rd, `OPC_OP_IMM, 2'b11}, rd != 5'd0, rd, exp,
                (f3[2:1] == 2'b01) ? 66 : 34, 32'd0);
   endtask

   task automatic op_reg(input logic alt, input funct3_t f3, input reg_addr_t rd,
                         input reg_addr_t rs1, input reg_addr_t rs2);
      word_t exp;
      exp = expected_result(f3, alt, model[rs1], model[rs2]);
      run_instr({1'b0, alt, 5'd0, rs2, rs1, f3, rd, `OPC_OP, 2'b11}, rd != 5'd0, rd, exp,
                (f3[2:1] == 2'b01) ? 66 : 34, 32'd0);
   endtask

   // lui rounds up so the sign-extended addi lands on value.
   task automatic load_const(input reg_addr_t rd, input word_t value);
      word_t upper;
      upper = value + 32'h800;
      run_instr({upper[31:12], rd, `OPC_LUI, 2'b11}, 1'b1, rd, {upper[31:12], 12'd0}, 34,
                32'd0);
      op_imm(3'b000, rd, rd, value[11:0]);
      compare_value("o_rd_data", o_rd_data, value);
   endtask

   task automatic test_reset_idle();
      repeat (10) begin
         compare_value("o_busy", {31'd0, o_busy}, 32'd0);
         compare_value("o_retire", {31'd0, o_retire}, 32'd0);
         @(negedge clk);
      end
   endtask

   task automatic test_fill_regs();
      for (int r = 1; r < `NUM_REGS; r++) begin
         load_const(r[4:0], lcg_next());
      end
   endtask

   task automatic test_alu_ops();
      word_t     rnd;
      reg_addr_t rd;
      for (int i = 0; i < 8; i++) begin
         rnd = lcg_next();
         rd  = (rnd[4:0] == 5'd0) ? 5'd31 : rnd[4:0];
         op_reg(1'b0, 3'b000, rd, rnd[9:5], rnd[14:10]);
         op_reg(1'b1, 3'b000, rd, rnd[14:10], rnd[9:5]);
         op_reg(1'b0, 3'b100, rd, rnd[9:5], rnd[14:10]);
         op_reg(1'b0, 3'b110, rd, rnd[14:10], rnd[9:5]);
         op_reg(1'b0, 3'b111, rd, rnd[9:5], rnd[14:10]);
         op_imm(3'b000, rd, rnd[9:5], rnd[31:20]);
         op_imm(3'b100, rd, rnd[14:10], rnd[31:20]);
         op_imm(3'b110, rd, rnd[9:5], rnd[31:20]);
         op_imm(3'b111, rd, rnd[14:10], rnd[31:20]);
      end
      op_imm(3'b000, 5'd7, 5'd3, 12'hf9c); // minus 100.
   endtask

   task automatic test_compares();
      load_const(5'd1, 32'h8000_0000);
      load_const(5'd2, 32'd5);
      load_const(5'd3, 32'hffff_ffff);
      load_const(5'd4, 32'd1);
      load_const(5'd5, 32'd5);
      for (int f = 2; f < 4; f++) begin
         op_reg(1'b0, f[2:0], 5'd10, 5'd2, 5'd5);
         op_reg(1'b0, f[2:0], 5'd10, 5'd1, 5'd2);
         op_reg(1'b0, f[2:0], 5'd10, 5'd2, 5'd1);
         op_reg(1'b0, f[2:0], 5'd10, 5'd3, 5'd4);
         op_reg(1'b0, f[2:0], 5'd10, 5'd4, 5'd3);
         op_imm(f[2:0], 5'd11, 5'd2, 12'd5);
         op_imm(f[2:0], 5'd11, 5'd1, 12'd1);
         op_imm(f[2:0], 5'd11, 5'd3, 12'd1);
         op_imm(f[2:0], 5'd11, 5'd4, 12'hfff);
      end
   endtask

   task automatic test_x0_and_illegal();
      op_imm(3'b000, 5'd0, 5'd1, 12'd123);
      op_reg(1'b0, 3'b000, 5'd6, 5'd0, 5'd0);
      op_imm(3'b110, 5'd7, 5'd0, 12'h05a);
      run_instr({12'd4, 5'd1, 3'b010, 5'd8, 5'b00000, 2'b11}, 1'b0, 5'd8, 32'd0, 34, 32'd0);
      run_instr({12'd3, 5'd1, 3'b001, 5'd8, `OPC_OP_IMM, 2'b11}, 1'b0, 5'd8, 32'd0, 34,
                32'd0);
      op_reg(1'b0, 3'b000, 5'd9, 5'd8, 5'd0); // x8 kept its value.
   endtask

   task automatic test_busy_strobe();
      int extra;
      extra = 0;
      run_instr({12'd1, 5'd5, 3'b000, 5'd5, `OPC_OP_IMM, 2'b11}, 1'b1, 5'd5,
                model[5] + 32'd1, 34, {12'd77, 5'd6, 3'b000, 5'd6, `OPC_OP_IMM, 2'b11});
      repeat (80) begin
         @(negedge clk);
         extra += int'(o_retire);
      end
      assert (extra == 0) else begin
         $display("a strobe issued while busy led to %0d extra retirements", extra);
         errors++;
      end
      op_reg(1'b0, 3'b000, 5'd6, 5'd6, 5'd0);
   endtask

   initial begin
      i_rst    = 1'b1;
      i_wb_en  = 1'b0;
      i_wb_rdt = '0;
      for (int r = 0; r < `NUM_REGS; r++) begin
         model[r] = '0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      test_reset_idle();
      test_fill_regs();
      test_alu_ops();
      test_compares();
      test_x0_and_illegal();
      test_busy_strobe();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/serial_core_pkg.sv
design/serial_decode.sv
design/serial_regfile.sv
design/serial_alu.sv
design/serial_core.sv
tb/serial_core_asserts.sv
tb/serial_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the serial core testbench with Verilator, run it, scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module serial_core_tb \
   -o serial_core_sim \
   && ./obj_dir/serial_core_sim 2>&1 | tee sim.log \
   || { echo "build or simulation did not complete"; exit 1; }
! grep -q "STATUS: FAIL" sim.log
